/* isa_pkg.sv */
// RV32 instruction set constants and the two-view instruction word
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////
  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_LOAD  = 7'h03;
  localparam logic [6:0] OPCODE_STORE = 7'h23;
  localparam logic [6:0] OPCODE_AMO   = 7'h2f;

  // Funct7 values legal on OP
  localparam logic [6:0] FUNCT7_ZERO   = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b010_0000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;

  ////////////////////////////////////////
  // AMO funct5 codes
  ////////////////////////////////////////
  localparam logic [4:0] AMO_LR   = 5'b00010;
  localparam logic [4:0] AMO_SC   = 5'b00011;
  localparam logic [4:0] AMO_SWAP = 5'b00001;
  localparam logic [4:0] AMO_ADD  = 5'b00000;
  localparam logic [4:0] AMO_XOR  = 5'b00100;
  localparam logic [4:0] AMO_AND  = 5'b01100;
  localparam logic [4:0] AMO_OR   = 5'b01000;
  localparam logic [4:0] AMO_MIN  = 5'b10000;
  localparam logic [4:0] AMO_MAX  = 5'b10100;
  localparam logic [4:0] AMO_MINU = 5'b11000;
  localparam logic [4:0] AMO_MAXU = 5'b11100;

  // Plain register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // Atomic layout, funct7 split into funct5 and ordering bits
  typedef struct packed {
    logic [4:0] funct5;
    logic       aq;
    logic       rl;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } amo_t;

  // Same 32 bits, read either way
  typedef union packed {
    rtype_t rtype;
    amo_t   amo;
  } instr_u;

endpackage

`default_nettype wire

/* ctrl_pkg.sv */
// Decoder control word types, illegal default and flow-control depths
`default_nettype none

package ctrl_pkg;

  ////////////////////////////////////////
  // Operator and operand source encodings
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REGA_OR_FWD, OP_A_IMM, OP_A_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REGB_OR_FWD, OP_B_IMM, OP_B_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REGB_OR_FWD, OP_C_IMM, OP_C_NONE} op_c_sel_e;

  // Decoded control word, 29 bits
  typedef struct packed {
    logic       illegal_insn;
    logic       alu_en;
    alu_op_e    alu_operator;
    op_a_sel_e  alu_op_a_mux_sel;
    op_b_sel_e  alu_op_b_mux_sel;
    op_c_sel_e  op_c_mux_sel;
    logic       mul_en;
    logic       div_en;
    logic [1:0] rf_re;
    logic       rf_we;
    logic       data_req;
    logic       data_we;
    logic [1:0] data_type;        // 00 word, 01 half, 10 byte
    logic       data_sign_ext;
    logic [5:0] data_atop;        // MSB flags an atomic
    logic       prepost_useincr;
  } decoder_ctrl_t;

  // Illegal flag up, every enable down
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn:     1'b1,
    alu_en:           1'b0,
    alu_operator:     ALU_SLTU,
    alu_op_a_mux_sel: OP_A_REGA_OR_FWD,
    alu_op_b_mux_sel: OP_B_REGB_OR_FWD,
    op_c_mux_sel:     OP_C_NONE,
    mul_en:           1'b0,
    div_en:           1'b0,
    rf_re:            2'b00,
    rf_we:            1'b0,
    data_req:         1'b0,
    data_we:          1'b0,
    data_type:        2'b00,
    data_sign_ext:    1'b0,
    data_atop:        6'b00_0000,
    prepost_useincr:  1'b1
  };

  ////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////
  localparam int unsigned FETCH_DEPTH = 4;
  localparam int unsigned ID_CREDITS  = 1;
  localparam int unsigned EX_CREDITS  = 2;

  localparam int unsigned FETCH_PTR_W = $clog2(FETCH_DEPTH);
  localparam int unsigned FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned ID_CRED_W   = $clog2(ID_CREDITS + 1);
  localparam int unsigned EX_CRED_W   = $clog2(EX_CREDITS + 1);

  // Last queue slot, for pointer wrap
  localparam logic [FETCH_PTR_W-1:0] FETCH_PTR_LAST = FETCH_PTR_W'(FETCH_DEPTH - 1);

endpackage

`default_nettype wire

/* instr_if.sv */
// Fetch buffer to decode stage link carrying one instruction per valid and a credit back
`timescale 1ns/1ns
`default_nettype none

interface instr_if;

  logic            valid;
  isa_pkg::instr_u instr;
  logic [31:0]     pc;
  // One pulse per entry the decode stage frees
  logic            credit;

  modport sender (output valid, output instr, output pc, input credit);
  modport receiver (input valid, input instr, input pc, output credit);

endinterface

`default_nettype wire

/* if_buffer.sv */
// Fetch queue, filled against fetch credits and drained under decode credits
`timescale 1ns/1ns
`default_nettype none

module if_buffer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            fetch_valid_i,
  input  isa_pkg::instr_u fetch_instr_i,
  input  logic [31:0]     fetch_pc_i,
  output logic            fetch_credit_o,
  instr_if.sender         out_if
);

  // Payload storage
  isa_pkg::instr_u instr_mem [ctrl_pkg::FETCH_DEPTH];
  logic [31:0]     pc_mem    [ctrl_pkg::FETCH_DEPTH];

  // Queue state
  logic [ctrl_pkg::FETCH_PTR_W-1:0] wr_ptr_q;
  logic [ctrl_pkg::FETCH_PTR_W-1:0] rd_ptr_q;
  logic [ctrl_pkg::FETCH_CNT_W-1:0] count_q;
  logic [ctrl_pkg::ID_CRED_W-1:0]   id_credit_q;

  logic push;
  logic pop;

  // Source never sends without a credit, so every valid word has a free slot
  assign push = fetch_valid_i;
  // Transfer whenever there is a word and room downstream
  assign pop  = (count_q != '0) && (id_credit_q != '0);

  assign out_if.valid   = pop;
  assign out_if.instr   = instr_mem[rd_ptr_q];
  assign out_if.pc      = pc_mem[rd_ptr_q];
  // Freed slot goes straight back to the source
  assign fetch_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      instr_mem[wr_ptr_q] <= fetch_instr_i;
      pc_mem[wr_ptr_q]    <= fetch_pc_i;
    end
  end

  ////////////////////////////////////////
  // Pointers, fill level, decode credits
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      id_credit_q <= ctrl_pkg::ID_CRED_W'(ctrl_pkg::ID_CREDITS);
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ctrl_pkg::FETCH_PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ctrl_pkg::FETCH_PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the level alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Spend on pop, regain when the stage drains
      case ({pop, out_if.credit})
        2'b10:   id_credit_q <= id_credit_q - 1'b1;
        2'b01:   id_credit_q <= id_credit_q + 1'b1;
        default: id_credit_q <= id_credit_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* id_i_decoder.sv */
// Base integer decode for OP, OP-IMM, LOAD and STORE
`timescale 1ns/1ns
`default_nettype none

module id_i_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  logic [2:0] funct3;
  logic       is_imm;
  logic       f7_zero;
  logic       f7_alt;

  assign funct3  = instr_i.rtype.funct3;
  assign is_imm  = (instr_i.rtype.opcode == isa_pkg::OPCODE_OPIMM);
  assign f7_zero = (instr_i.rtype.funct7 == isa_pkg::FUNCT7_ZERO);
  assign f7_alt  = (instr_i.rtype.funct7 == isa_pkg::FUNCT7_ALT);

  always_comb begin
    decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;

    unique case (instr_i.rtype.opcode)
      ////////////////////////////////////////
      // ALU forms
      ////////////////////////////////////////
      isa_pkg::OPCODE_OP, isa_pkg::OPCODE_OPIMM: begin
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        decoder_ctrl_o.rf_re            = is_imm ? 2'b01 : 2'b11;
        decoder_ctrl_o.alu_op_a_mux_sel = ctrl_pkg::OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = is_imm ? ctrl_pkg::OP_B_IMM
                                                 : ctrl_pkg::OP_B_REGB_OR_FWD;
        unique case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator = (f7_alt && !is_imm) ? ctrl_pkg::ALU_SUB
                                                                     : ctrl_pkg::ALU_ADD;
          3'b001:  decoder_ctrl_o.alu_operator = ctrl_pkg::ALU_SLL;
          3'b010:  decoder_ctrl_o.alu_operator = ctrl_pkg::ALU_SLT;
          3'b011:  decoder_ctrl_o.alu_operator = ctrl_pkg::ALU_SLTU;
          3'b100:  decoder_ctrl_o.alu_operator = ctrl_pkg::ALU_XOR;
          3'b101:  decoder_ctrl_o.alu_operator = f7_alt ? ctrl_pkg::ALU_SRA : ctrl_pkg::ALU_SRL;
          3'b110:  decoder_ctrl_o.alu_operator = ctrl_pkg::ALU_OR;
          default: decoder_ctrl_o.alu_operator = ctrl_pkg::ALU_AND;
        endcase
        // Immediates only constrain funct7 on shifts; register forms allow alt on sub/sra
        if (is_imm) begin
          decoder_ctrl_o.illegal_insn = (funct3[1:0] == 2'b01) && !f7_zero
                                        && !(f7_alt && funct3[2]);
        end else begin
          decoder_ctrl_o.illegal_insn = !(f7_zero
                                          || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        end
        if (decoder_ctrl_o.illegal_insn) begin
          decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      ////////////////////////////////////////
      // Memory access
      ////////////////////////////////////////
      isa_pkg::OPCODE_LOAD, isa_pkg::OPCODE_STORE: begin
        decoder_ctrl_o.data_req         = 1'b1;
        decoder_ctrl_o.alu_operator     = ctrl_pkg::ALU_ADD;
        decoder_ctrl_o.alu_op_a_mux_sel = ctrl_pkg::OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = ctrl_pkg::OP_B_IMM;
        // Funct3 size codes 00 byte, 01 half and 10 word
        unique case (funct3[1:0])
          2'b00:   decoder_ctrl_o.data_type = 2'b10;
          2'b01:   decoder_ctrl_o.data_type = 2'b01;
          default: decoder_ctrl_o.data_type = 2'b00;
        endcase
        if (instr_i.rtype.opcode == isa_pkg::OPCODE_LOAD) begin
          decoder_ctrl_o.rf_re         = 2'b01;
          decoder_ctrl_o.rf_we         = 1'b1;
          decoder_ctrl_o.data_sign_ext = !funct3[2];
          // No 11 size, no unsigned word
          decoder_ctrl_o.illegal_insn  = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
        end else begin
          decoder_ctrl_o.rf_re        = 2'b11;
          decoder_ctrl_o.data_we      = 1'b1;
          decoder_ctrl_o.op_c_mux_sel = ctrl_pkg::OP_C_REGB_OR_FWD;
          decoder_ctrl_o.illegal_insn = funct3[2] || (funct3[1:0] == 2'b11);
        end
        if (decoder_ctrl_o.illegal_insn) begin
          decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      default: begin
        decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;
      end
    endcase
  end

endmodule

`default_nettype wire

/* id_m_decoder.sv */
// RV32M multiply and divide decode
`timescale 1ns/1ns
`default_nettype none

module id_m_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  always_comb begin
    decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;

    // Only OP with the muldiv funct7 belongs here
    if (instr_i.rtype.opcode == isa_pkg::OPCODE_OP &&
        instr_i.rtype.funct7 == isa_pkg::FUNCT7_MULDIV) begin
      decoder_ctrl_o.illegal_insn     = 1'b0;
      decoder_ctrl_o.rf_re            = 2'b11;
      decoder_ctrl_o.rf_we            = 1'b1;
      decoder_ctrl_o.alu_op_a_mux_sel = ctrl_pkg::OP_A_REGA_OR_FWD;
      decoder_ctrl_o.alu_op_b_mux_sel = ctrl_pkg::OP_B_REGB_OR_FWD;
      // mul, mulh, mulhsu, mulhu on the low half
      // div, divu, rem, remu on the high half
      decoder_ctrl_o.mul_en           = !instr_i.rtype.funct3[2];
      decoder_ctrl_o.div_en           = instr_i.rtype.funct3[2];
    end
  end

endmodule

`default_nettype wire

/* id_a_decoder.sv */
// RV32A atomic memory operation decode, word width only
`timescale 1ns/1ns
`default_nettype none

module id_a_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  always_comb begin
    decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;

    if (instr_i.amo.opcode == isa_pkg::OPCODE_AMO && instr_i.amo.funct3 == 3'b010) begin
      decoder_ctrl_o.illegal_insn     = 1'b0;
      decoder_ctrl_o.data_req         = 1'b1;
      decoder_ctrl_o.data_type        = 2'b00;
      decoder_ctrl_o.data_sign_ext    = 1'b1;
      decoder_ctrl_o.rf_re            = 2'b11;
      decoder_ctrl_o.rf_we            = 1'b1;
      // Address is rs1 as is, no offset added
      decoder_ctrl_o.prepost_useincr  = 1'b0;
      decoder_ctrl_o.alu_op_a_mux_sel = ctrl_pkg::OP_A_REGA_OR_FWD;
      // Comparator for min/max
      decoder_ctrl_o.alu_en           = 1'b1;
      decoder_ctrl_o.alu_operator     = ctrl_pkg::ALU_SLTU;
      decoder_ctrl_o.data_atop        = {1'b1, instr_i.amo.funct5};

      unique case (instr_i.amo.funct5)
        // Load-reserved only reads
        isa_pkg::AMO_LR: begin
          decoder_ctrl_o.data_we = 1'b0;
        end
        isa_pkg::AMO_SC, isa_pkg::AMO_SWAP, isa_pkg::AMO_ADD,
        isa_pkg::AMO_XOR, isa_pkg::AMO_AND, isa_pkg::AMO_OR,
        isa_pkg::AMO_MIN, isa_pkg::AMO_MAX, isa_pkg::AMO_MINU,
        isa_pkg::AMO_MAXU: begin
          decoder_ctrl_o.data_we      = 1'b1;
          // Store data rides on operand c
          decoder_ctrl_o.op_c_mux_sel = ctrl_pkg::OP_C_REGB_OR_FWD;
        end
        default: begin
          decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* id_decoder.sv */
// Instruction decoder merging base, multiply and atomic sub-decoders
`timescale 1ns/1ns
`default_nettype none

module id_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  ctrl_pkg::decoder_ctrl_t i_ctrl;
  ctrl_pkg::decoder_ctrl_t m_ctrl;
  ctrl_pkg::decoder_ctrl_t a_ctrl;

  id_i_decoder u_i_decoder (.instr_i(instr_i), .decoder_ctrl_o(i_ctrl));
  id_m_decoder u_m_decoder (.instr_i(instr_i), .decoder_ctrl_o(m_ctrl));
  id_a_decoder u_a_decoder (.instr_i(instr_i), .decoder_ctrl_o(a_ctrl));

  // Encoding spaces are disjoint, so at most one claims the word
  always_comb begin
    if (!i_ctrl.illegal_insn) begin
      decoder_ctrl_o = i_ctrl;
    end else if (!m_ctrl.illegal_insn) begin
      decoder_ctrl_o = m_ctrl;
    end else if (!a_ctrl.illegal_insn) begin
      decoder_ctrl_o = a_ctrl;
    end else begin
      decoder_ctrl_o = ctrl_pkg::DECODER_CTRL_ILLEGAL_INSN;
    end
  end

endmodule

`default_nettype wire

/* id_stage.sv */
// Decode register stage with credit-based handoff toward execute
`timescale 1ns/1ns
`default_nettype none

module id_stage (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  instr_if.receiver               in_if,
  output logic                    ex_valid_o,
  output logic [31:0]             ex_pc_o,
  output ctrl_pkg::decoder_ctrl_t ex_ctrl_o,
  input  logic                    ex_credit_i
);

  ctrl_pkg::decoder_ctrl_t dec_ctrl;
  ctrl_pkg::decoder_ctrl_t ctrl_q;
  logic [31:0]             pc_q;
  logic                    occupied_q;
  logic [ctrl_pkg::EX_CRED_W-1:0] ex_credit_q;
  logic                    send;

  id_decoder u_decoder (
    .instr_i        (in_if.instr),
    .decoder_ctrl_o (dec_ctrl)
  );

  // Held entry leaves as soon as execute has room
  assign send = occupied_q && (ex_credit_q != '0);

  assign ex_valid_o   = send;
  assign ex_pc_o      = pc_q;
  assign ex_ctrl_o    = ctrl_q;
  // Slot freed, tell the fetch buffer
  assign in_if.credit = send;

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (in_if.valid) begin
      pc_q   <= in_if.pc;
      ctrl_q <= dec_ctrl;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occupied_q  <= 1'b0;
      ex_credit_q <= ctrl_pkg::EX_CRED_W'(ctrl_pkg::EX_CREDITS);
    end else begin
      // Upstream only sends into an empty register
      if (in_if.valid) begin
        occupied_q <= 1'b1;
      end else if (send) begin
        occupied_q <= 1'b0;
      end
      // Spend on send, refill on return pulse
      case ({send, ex_credit_i})
        2'b10:   ex_credit_q <= ex_credit_q - 1'b1;
        2'b01:   ex_credit_q <= ex_credit_q + 1'b1;
        default: ex_credit_q <= ex_credit_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* decode_top.sv */
// Decode subsystem top: fetch queue and decode stage on flat ports
`timescale 1ns/1ns
`default_nettype none

module decode_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // Fetch side
  input  logic              fetch_valid_i,
  input  logic [31:0]       fetch_instr_i,
  input  logic [31:0]       fetch_pc_i,
  output logic              fetch_credit_o,
  // Execute side
  output logic              ex_valid_o,
  output logic [31:0]       ex_pc_o,
  output logic              ex_illegal_o,
  output logic              ex_alu_en_o,
  output ctrl_pkg::alu_op_e ex_alu_operator_o,
  output logic              ex_mul_en_o,
  output logic              ex_div_en_o,
  output logic              ex_rf_we_o,
  output logic              ex_data_req_o,
  output logic              ex_data_we_o,
  output logic [5:0]        ex_data_atop_o,
  input  logic              ex_credit_i
);

  ctrl_pkg::decoder_ctrl_t ex_ctrl;

  instr_if instr_bus ();

  if_buffer u_if_buffer (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_pc_i     (fetch_pc_i),
    .fetch_credit_o (fetch_credit_o),
    .out_if         (instr_bus.sender)
  );

  id_stage u_id_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_if       (instr_bus.receiver),
    .ex_valid_o  (ex_valid_o),
    .ex_pc_o     (ex_pc_o),
    .ex_ctrl_o   (ex_ctrl),
    .ex_credit_i (ex_credit_i)
  );

  // Control word fields out to execute
  assign ex_illegal_o      = ex_ctrl.illegal_insn;
  assign ex_alu_en_o       = ex_ctrl.alu_en;
  assign ex_alu_operator_o = ex_ctrl.alu_operator;
  assign ex_mul_en_o       = ex_ctrl.mul_en;
  assign ex_div_en_o       = ex_ctrl.div_en;
  assign ex_rf_we_o        = ex_ctrl.rf_we;
  assign ex_data_req_o     = ex_ctrl.data_req;
  assign ex_data_we_o      = ex_ctrl.data_we;
  assign ex_data_atop_o    = ex_ctrl.data_atop;

endmodule

`default_nettype wire

/* tb_decode_tasks.svh */
// Reference decode model, fetch driver and directed tests for the decode testbench
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

  // ALU operator from funct3, alt picks sub or sra
  function automatic logic [3:0] alu_for_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ctrl_pkg::ALU_SUB : ctrl_pkg::ALU_ADD;
      3'd1:    return ctrl_pkg::ALU_SLL;
      3'd2:    return ctrl_pkg::ALU_SLT;
      3'd3:    return ctrl_pkg::ALU_SLTU;
      3'd4:    return ctrl_pkg::ALU_XOR;
      3'd5:    return alt ? ctrl_pkg::ALU_SRA : ctrl_pkg::ALU_SRL;
      3'd6:    return ctrl_pkg::ALU_OR;
      default: return ctrl_pkg::ALU_AND;
    endcase
  endfunction

  function automatic logic is_listed_amo(input logic [4:0] f5);
    case (f5)
      isa_pkg::AMO_LR, isa_pkg::AMO_SC, isa_pkg::AMO_SWAP, isa_pkg::AMO_ADD,
      isa_pkg::AMO_XOR, isa_pkg::AMO_AND, isa_pkg::AMO_OR, isa_pkg::AMO_MIN,
      isa_pkg::AMO_MAX, isa_pkg::AMO_MINU, isa_pkg::AMO_MAXU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Expected {illegal, alu_en, alu_op, mul_en, div_en, rf_we, data_req, data_we, atop}
  function automatic logic [16:0] ref_decode(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] f5;
    logic [3:0] op;
    logic [5:0] atop;
    logic       illegal;
    logic       alu_en;
    logic       mul_en;
    logic       div_en;
    logic       rf_we;
    logic       req;
    logic       dwe;
    f3      = w[14:12];
    f7      = w[31:25];
    f5      = w[31:27];
    // Illegal default, comparator operator and all enables low
    illegal = 1'b1;
    alu_en  = 1'b0;
    op      = ctrl_pkg::ALU_SLTU;
    mul_en  = 1'b0;
    div_en  = 1'b0;
    rf_we   = 1'b0;
    req     = 1'b0;
    dwe     = 1'b0;
    atop    = '0;
    case (w[6:0])
      isa_pkg::OPCODE_OP: begin
        if (f7 == isa_pkg::FUNCT7_MULDIV) begin
          // Funct3 0..3 multiply, 4..7 divide
          illegal = 1'b0;
          rf_we   = 1'b1;
          mul_en  = (f3 < 3'd4);
          div_en  = (f3 >= 3'd4);
        end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          illegal = 1'b0;
          alu_en  = 1'b1;
          rf_we   = 1'b1;
          op      = alu_for_funct3(f3, f7 == 7'h20);
        end
      end
      isa_pkg::OPCODE_OPIMM: begin
        // Only the shifts constrain the upper bits
        if ((f3 != 3'd1 || f7 == 7'h00) && (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20)) begin
          illegal = 1'b0;
          alu_en  = 1'b1;
          rf_we   = 1'b1;
          op      = alu_for_funct3(f3, f3 == 3'd5 && f7 == 7'h20);
        end
      end
      isa_pkg::OPCODE_LOAD: begin
        // lb lh lw lbu lhu
        if (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7) begin
          illegal = 1'b0;
          rf_we   = 1'b1;
          req     = 1'b1;
          op      = ctrl_pkg::ALU_ADD;
        end
      end
      isa_pkg::OPCODE_STORE: begin
        if (f3 < 3'd3) begin
          illegal = 1'b0;
          req     = 1'b1;
          dwe     = 1'b1;
          op      = ctrl_pkg::ALU_ADD;
        end
      end
      isa_pkg::OPCODE_AMO: begin
        // Word width only, LR is the one read
        if (f3 == 3'b010 && is_listed_amo(f5)) begin
          illegal = 1'b0;
          alu_en  = 1'b1;
          rf_we   = 1'b1;
          req     = 1'b1;
          dwe     = (f5 != isa_pkg::AMO_LR);
          atop    = {1'b1, f5};
        end
      end
      default: begin
      end
    endcase
    return {illegal, alu_en, op, mul_en, div_en, rf_we, req, dwe, atop};
  endfunction

  ////////////////////////////////////////
  // Fetch driver
  ////////////////////////////////////////
  // Waits for a free fetch credit, pc is unique per word
  task automatic send_word(input logic [31:0] instr);
    logic [31:0] pc;
    pc = 32'h0001_0000 + 32'(sent_cnt * 4);
    @(posedge clk);
    while (sent_cnt - pops_seen >= int'(ctrl_pkg::FETCH_DEPTH)) begin
      fetch_valid <= 1'b0;
      @(posedge clk);
    end
    fetch_valid <= 1'b1;
    fetch_instr <= instr;
    fetch_pc    <= pc;
    exp_mem[sent_cnt[9:0]] = {pc, ref_decode(instr)};
    sent_cnt++;
  endtask

  task automatic stop_fetch();
    @(posedge clk);
    fetch_valid <= 1'b0;
  endtask

  // Every word out and every execute credit back
  task automatic wait_idle();
    while (items_received != sent_cnt || credits_returned != items_received) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic check_reset_latency();
    credit_mode = 1;
    repeat (4) begin
      @(negedge clk);
      assert (!fetch_credit && !ex_valid) else begin
        seq_errors++;
        $display("%0t: fetch credit or output active right after reset", $time);
      end
    end
    // sub x1, x2, x3
    send_word({7'h20, 5'd3, 5'd2, 3'd0, 5'd1, isa_pkg::OPCODE_OP});
    stop_fetch();
    // One cycle after the drive edge the word is only queued
    @(negedge clk);
    assert (!ex_valid) else begin
      seq_errors++;
      $display("MISMATCH %0t: output one cycle after drive, expected two", $time);
    end
    @(negedge clk);
    assert (ex_valid) else begin
      seq_errors++;
      $display("MISMATCH %0t: no output two cycles after drive", $time);
    end
    wait_idle();
  endtask

  task automatic sweep_amo_codes();
    logic [31:0] r;
    for (int f5 = 0; f5 < 32; f5++) begin
      for (int wd = 0; wd < 2; wd++) begin
        r = $random(seed);
        // Word width, then the doubleword width
        send_word({f5[4:0], r[1:0], r[24:15], (wd == 0) ? 3'b010 : 3'b011, r[11:7],
                   isa_pkg::OPCODE_AMO});
      end
    end
    stop_fetch();
    wait_idle();
  endtask

  task automatic cover_base_forms();
    logic [31:0] r;
    logic [6:0]  op_f7 [4];
    logic [6:0]  imm_f7 [3];
    logic [6:0]  other_ops [8];
    op_f7     = '{7'h00, 7'h20, 7'h01, 7'h05};
    imm_f7    = '{7'h00, 7'h20, 7'h11};
    // Branch, jal, jalr, system, fence, lui, auipc, compressed
    other_ops = '{7'h63, 7'h6f, 7'h67, 7'h73, 7'h0f, 7'h37, 7'h17, 7'h01};
    for (int f3 = 0; f3 < 8; f3++) begin
      r = $random(seed);
      for (int k = 0; k < 4; k++) begin
        send_word({op_f7[k], r[24:15], f3[2:0], r[11:7], isa_pkg::OPCODE_OP});
      end
      for (int k = 0; k < 3; k++) begin
        send_word({imm_f7[k], r[24:15], f3[2:0], r[11:7], isa_pkg::OPCODE_OPIMM});
      end
      send_word({r[31:15], f3[2:0], r[11:7], isa_pkg::OPCODE_LOAD});
      send_word({r[31:15], f3[2:0], r[11:7], isa_pkg::OPCODE_STORE});
    end
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      send_word({r[31:7], other_ops[k]});
    end
    stop_fetch();
    wait_idle();
  endtask

  task automatic hold_execute_credits();
    int start;
    start       = items_received;
    credit_mode = 0;
    // or x2, x1, xk
    for (int k = 0; k < 6; k++) begin
      send_word({7'h00, 5'(k), 5'd1, 3'b110, 5'd2, isa_pkg::OPCODE_OP});
    end
    stop_fetch();
    repeat (40) @(posedge clk);
    assert (items_received - start == int'(ctrl_pkg::EX_CREDITS)) else begin
      seq_errors++;
      $display("%0t: %0d outputs while execute credits were held, expected %0d", $time,
               items_received - start, ctrl_pkg::EX_CREDITS);
    end
    credit_mode = 1;
    wait_idle();
  endtask

  task automatic run_random_stream();
    logic [31:0] r;
    logic [31:0] w;
    credit_mode = 2;
    for (int n = 0; n < RANDOM_WORDS; n++) begin
      r = $random(seed);
      w = $random(seed);
      // Lean toward decoded opcodes, some raw words stay
      case (r[2:0])
        3'd0, 3'd1: w[6:0] = isa_pkg::OPCODE_OP;
        3'd2:       w[6:0] = isa_pkg::OPCODE_OPIMM;
        3'd3:       w[6:0] = isa_pkg::OPCODE_LOAD;
        3'd4:       w[6:0] = isa_pkg::OPCODE_STORE;
        3'd5, 3'd6: w[6:0] = isa_pkg::OPCODE_AMO;
        default:    w[6:0] = w[6:0];
      endcase
      if (w[6:0] == isa_pkg::OPCODE_AMO && r[3]) begin
        w[14:12] = 3'b010;
      end
      if (w[6:0] == isa_pkg::OPCODE_OP && r[4]) begin
        w[31:25] = r[5] ? 7'h01 : (r[6] ? 7'h20 : 7'h00);
      end
      // Occasional bubble on the fetch side
      if (r[9:8] == 2'b00) begin
        stop_fetch();
      end
      send_word(w);
    end
    stop_fetch();
    wait_idle();
  endtask

`endif

/* tb_decode_top.sv */
// Testbench for the decode subsystem with scoreboard, execute credit return and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_decode_top;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_WORDS = 200;
  // Latency probe, AMO sweep, base forms, held burst
  localparam int DIRECTED_WORDS = 1 + 64 + 80 + 6;
  // Budget per word covers random credit stalls, plus the held window
  localparam int WATCHDOG_NS = ((DIRECTED_WORDS + RANDOM_WORDS) * 16 + 400) * CLK_PERIOD;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              fetch_valid;
  logic [31:0]       fetch_instr;
  logic [31:0]       fetch_pc;
  logic              fetch_credit;
  logic              ex_valid;
  logic [31:0]       ex_pc;
  logic              ex_illegal;
  logic              ex_alu_en;
  ctrl_pkg::alu_op_e ex_alu_operator;
  logic              ex_mul_en;
  logic              ex_div_en;
  logic              ex_rf_we;
  logic              ex_data_req;
  logic              ex_data_we;
  logic [5:0]        ex_data_atop;
  logic              ex_credit;

  ////////////////////////////////////////
  // Scoreboard state
  ////////////////////////////////////////
  // Expected {pc, ctrl} in send order
  logic [48:0] exp_mem [1024];
  logic [48:0] got_word;
  int          sent_cnt         = 0;
  int          pops_seen        = 0;
  int          items_received   = 0;
  int          credits_returned = 0;
  // 0 hold, 1 return at once, 2 random return
  int          credit_mode      = 0;
  int          mon_errors       = 0;
  int          seq_errors       = 0;
  integer      seed             = 32'h3190;
  integer      credit_seed      = 32'h3190;
  logic [31:0] credit_rnd;

  decode_top dut0 (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .fetch_valid_i     (fetch_valid),
    .fetch_instr_i     (fetch_instr),
    .fetch_pc_i        (fetch_pc),
    .fetch_credit_o    (fetch_credit),
    .ex_valid_o        (ex_valid),
    .ex_pc_o           (ex_pc),
    .ex_illegal_o      (ex_illegal),
    .ex_alu_en_o       (ex_alu_en),
    .ex_alu_operator_o (ex_alu_operator),
    .ex_mul_en_o       (ex_mul_en),
    .ex_div_en_o       (ex_div_en),
    .ex_rf_we_o        (ex_rf_we),
    .ex_data_req_o     (ex_data_req),
    .ex_data_we_o      (ex_data_we),
    .ex_data_atop_o    (ex_data_atop),
    .ex_credit_i       (ex_credit)
  );

  `include "tb_decode_tasks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Output monitor, samples mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (fetch_credit) begin
        pops_seen++;
        assert (pops_seen <= sent_cnt) else begin
          mon_errors++;
          $display("%0t: fetch credit returned for a word never sent", $time);
        end
      end
      if (ex_valid) begin
        got_word = {ex_pc, ex_illegal, ex_alu_en, ex_alu_operator, ex_mul_en, ex_div_en,
                    ex_rf_we, ex_data_req, ex_data_we, ex_data_atop};
        assert (items_received < sent_cnt) else begin
          mon_errors++;
          $display("%0t: output appeared with no word pending", $time);
        end
        assert (got_word == exp_mem[items_received[9:0]]) else begin
          mon_errors++;
          $display("MISMATCH %0t: output %0d pc %h ctrl %h, expected pc %h ctrl %h", $time,
                   items_received, got_word[48:17], got_word[16:0],
                   exp_mem[items_received[9:0]][48:17], exp_mem[items_received[9:0]][16:0]);
        end
        items_received++;
      end
    end
  end

  // Execute side returns one credit per received word
  initial begin
    ex_credit <= 1'b0;
    forever begin
      @(posedge clk);
      credit_rnd = $random(credit_seed);
      if ((items_received > credits_returned) &&
          (credit_mode == 1 || (credit_mode == 2 && credit_rnd[1:0] != 2'b00))) begin
        ex_credit <= 1'b1;
        credits_returned++;
      end else begin
        ex_credit <= 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, %0d of %0d words delivered",
             WATCHDOG_NS, items_received, sent_cnt);
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    arst_n      <= 1'b0;
    fetch_valid <= 1'b0;
    fetch_instr <= '0;
    fetch_pc    <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    check_reset_latency();
    sweep_amo_codes();
    cover_base_forms();
    hold_execute_credits();
    run_random_stream();
    assert (items_received == sent_cnt && pops_seen == sent_cnt) else begin
      seq_errors++;
      $display("Words sent %0d, popped %0d, delivered %0d do not agree",
               sent_cnt, pops_seen, items_received);
    end
    $display("Errors: %0d (output checks %0d, sequence checks %0d) over %0d words",
             mon_errors + seq_errors, mon_errors, seq_errors, sent_cnt);
    if (mon_errors + seq_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
instr_if.sv
if_buffer.sv
id_i_decoder.sv
id_m_decoder.sv
id_a_decoder.sv
id_decoder.sv
id_stage.sv
decode_top.sv
tb_decode_top.sv

/* run.sh */
#!/bin/sh
# Build and run the decode testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns -f src.f \
  --top-module tb_decode_top -Mdir "$BUILD" -o Vtb_decode_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/Vtb_decode_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "test passed" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0
